// ==== include/core_defs.svh ====
// core-wide width, register and reset constants
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define XLEN 32

// integer register file size
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== source/isa_pkg.sv ====
// RV32I opcode, instruction class and ALU enums, decoded instruction struct
`default_nettype none
`include "core_defs.svh"

package isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        CLASS_R,
        CLASS_I,
        CLASS_S,
        CLASS_B,
        CLASS_U,
        CLASS_J,
        CLASS_NONE  // unknown opcode
    } inst_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0]             opcode;  // raw opcode field
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;     // sign extended
        inst_class_e            inst_class;
        alu_op_e                alu_op;
    } decoded_t;

endpackage

`default_nettype wire

// ==== source/bus_pkg.sv ====
// memory bus request struct and arbiter owner encoding
`default_nettype none
`include "core_defs.svh"

package bus_pkg;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic [3:0]       wmask;  // byte enables
        logic             write;
    } mem_req_t;

    // which peer holds the shared port
    typedef enum logic {
        OWNER_FETCH,
        OWNER_DATA
    } bus_owner_e;

endpackage

`default_nettype wire

// ==== source/fetch_unit.sv ====
// PC register, fetch and execute sequencing, instruction latch
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             reset,
    output logic             fetch_req,
    output logic [`XLEN-1:0] fetch_addr,
    input  logic             fetch_ack,
    input  logic [`XLEN-1:0] fetch_rdata,
    input  logic             retire,
    input  logic [`XLEN-1:0] next_pc,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] inst,
    output logic             executing
);

    typedef enum logic [1:0] {
        S_REQ,   // request raised this cycle
        S_WAIT,  // held until ack
        S_EXEC
    } state_t;

    state_t state, state_nxt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            S_REQ:   state_nxt = fetch_ack ? S_EXEC : S_WAIT;
            S_WAIT:  if (fetch_ack) state_nxt = S_EXEC;
            S_EXEC:  if (retire) state_nxt = S_REQ;
            default: state_nxt = S_REQ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_REQ;
            pc    <= `RESET_PC;
        end else begin
            state <= state_nxt;
            if (retire) pc <= next_pc;  // only leaves exec on retire
        end
    end

    // instruction word held for the whole execute phase
    always_ff @(posedge clk) begin
        if (fetch_req && fetch_ack) inst <= fetch_rdata;
    end

    // no request while reset is held
    assign fetch_req  = !reset && ((state == S_REQ) || (state == S_WAIT));
    assign fetch_addr = pc;
    assign executing  = (state == S_EXEC);

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
// RV32I decoder: fields, class, immediates and ALU operation
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module decode_unit
    import isa_pkg::*;
(
    input  logic [`XLEN-1:0] inst,
    output decoded_t         dec
);

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        dec        = '0;
        dec.opcode = opcode;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        unique case (opcode)
            OP_REG:                    dec.inst_class = CLASS_R;
            OP_IMM, OP_LOAD, OP_JALR:  dec.inst_class = CLASS_I;
            OP_STORE:                  dec.inst_class = CLASS_S;
            OP_BRANCH:                 dec.inst_class = CLASS_B;
            OP_LUI, OP_AUIPC:          dec.inst_class = CLASS_U;
            OP_JAL:                    dec.inst_class = CLASS_J;
            default:                   dec.inst_class = CLASS_NONE;
        endcase

        unique case (dec.inst_class)
            CLASS_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            CLASS_S: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            CLASS_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            CLASS_U: dec.imm = {inst[31:12], 12'b0};
            CLASS_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase

        // address and target arithmetic all use add
        dec.alu_op = ALU_ADD;
        if (opcode == OP_IMM || opcode == OP_REG) begin
            unique case (funct3)
                3'b000: begin
                    if (opcode == OP_REG && funct7[5]) dec.alu_op = ALU_SUB;
                end
                3'b001:  dec.alu_op = ALU_SLL;
                3'b010:  dec.alu_op = ALU_SLT;
                3'b011:  dec.alu_op = ALU_SLTU;
                3'b100:  dec.alu_op = ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // bit 30 picks arith
                3'b110:  dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
// operand select, ALU, branch decision, next PC and writeback value
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module execute_unit
    import isa_pkg::*;
(
    input  decoded_t         dec,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    output logic [`XLEN-1:0] alu_result,
    output logic [`XLEN-1:0] wb_data,
    output logic             wb_en,
    output logic [`XLEN-1:0] next_pc
);

    logic [`XLEN-1:0] alu_a, alu_b, pc_plus4;
    logic             taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        unique case (dec.inst_class)
            CLASS_R: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            CLASS_U: begin
                alu_a = (dec.opcode == OP_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            CLASS_B, CLASS_J: begin  // pc relative target
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = dec.imm;
            end
        endcase
    end

    always_comb begin
        unique case (dec.alu_op)
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // branch condition on register operands
    always_comb begin
        unique case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;
        wb_data = alu_result;
        wb_en   = 1'b0;
        if (dec.opcode == OP_JAL) begin
            next_pc = alu_result;
            wb_data = pc_plus4;  // link
            wb_en   = 1'b1;
        end else if (dec.opcode == OP_JALR) begin
            next_pc = {alu_result[`XLEN-1:1], 1'b0};
            wb_data = pc_plus4;
            wb_en   = 1'b1;
        end else if (dec.inst_class == CLASS_B) begin
            if (taken) next_pc = alu_result;
        end else if (dec.inst_class inside {CLASS_R, CLASS_I, CLASS_U}) begin
            wb_en = 1'b1;  // loads get replaced in mem stage
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
// word load and store requests, writeback select and retire strobe
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module mem_stage
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             executing,
    input  decoded_t         dec,
    input  logic [`XLEN-1:0] alu_result,
    input  logic [`XLEN-1:0] store_data,
    input  logic [`XLEN-1:0] wb_data,
    input  logic             wb_en,
    output logic             data_req,
    output mem_req_t         data_req_data,
    input  logic             data_ack,
    input  logic [`XLEN-1:0] data_rdata,
    output logic             rf_we,
    output logic [`XLEN-1:0] rf_wdata,
    output logic             retire
);

    logic is_load, is_store, is_mem;
    logic data_done;  // ack already seen for this instruction

    assign is_load  = (dec.opcode == OP_LOAD) && (dec.funct3 == 3'b010);
    assign is_store = (dec.opcode == OP_STORE) && (dec.funct3 == 3'b010);
    assign is_mem   = is_load || is_store;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_done <= 1'b0;
        end else if (!executing) begin
            data_done <= 1'b0;
        end else if (data_req && data_ack) begin
            data_done <= 1'b1;
        end
    end

    // held from the first execute cycle until ack
    assign data_req = executing && is_mem && !data_done;

    always_comb begin
        data_req_data       = '0;
        data_req_data.addr  = alu_result;
        data_req_data.wdata = store_data;
        data_req_data.wmask = 4'hf;  // word access only
        data_req_data.write = is_store;
    end

    assign retire   = is_mem ? data_req && data_ack : executing;
    assign rf_we    = retire && wb_en;
    assign rf_wdata = is_load ? data_rdata : wb_data;

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
// shared memory port arbiter, fetch first, ack routed to owner
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module mem_arbiter
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             fetch_req,
    input  logic [`XLEN-1:0] fetch_addr,
    output logic             fetch_ack,
    output logic [`XLEN-1:0] fetch_rdata,
    input  logic             data_req,
    input  mem_req_t         data_req_data,
    output logic             data_ack,
    output logic [`XLEN-1:0] data_rdata,
    output logic             mem_req,
    output mem_req_t         mem_req_data,
    input  logic             mem_ack,
    input  logic [`XLEN-1:0] mem_rdata
);

    bus_owner_e grant, owner_q, owner;
    logic       busy;  // request forwarded, ack pending
    mem_req_t   fetch_rd;

    assign grant = fetch_req ? OWNER_FETCH : OWNER_DATA;
    assign owner = busy ? owner_q : grant;  // keep the owner while in flight

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            owner_q <= OWNER_FETCH;
        end else if (mem_ack) begin
            busy <= 1'b0;
        end else if (mem_req && !busy) begin
            busy    <= 1'b1;
            owner_q <= grant;
        end
    end

    always_comb begin
        fetch_rd      = '0;  // plain read
        fetch_rd.addr = fetch_addr;
    end

    assign mem_req      = (owner == OWNER_FETCH) ? fetch_req : data_req;
    assign mem_req_data = (owner == OWNER_FETCH) ? fetch_rd : data_req_data;

    assign fetch_ack   = mem_ack && (owner == OWNER_FETCH);
    assign data_ack    = mem_ack && (owner == OWNER_DATA);
    assign fetch_rdata = (owner == OWNER_FETCH) ? mem_rdata : '0;
    assign data_rdata  = (owner == OWNER_DATA) ? mem_rdata : '0;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// integer register file, two read ports, one write port
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (we && (waddr != '0)) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
// multicycle RV32I core top, units sharing one memory port
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module rv_core
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    output logic             mem_req,
    output mem_req_t         mem_req_data,
    input  logic             mem_ack,
    input  logic [`XLEN-1:0] mem_rdata,
    output logic             retire
);

    logic             fetch_req, fetch_ack, executing;
    logic [`XLEN-1:0] fetch_addr, fetch_rdata;
    logic [`XLEN-1:0] pc, inst, next_pc;
    logic             data_req, data_ack;
    mem_req_t         data_req_data;
    logic [`XLEN-1:0] data_rdata;
    decoded_t         dec;
    logic [`XLEN-1:0] rs1_data, rs2_data;
    logic [`XLEN-1:0] alu_result, wb_data, rf_wdata;
    logic             wb_en, rf_we;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ack   (fetch_ack),
        .fetch_rdata (fetch_rdata),
        .retire      (retire),
        .next_pc     (next_pc),
        .pc          (pc),
        .inst        (inst),
        .executing   (executing)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata)
    );

    execute_unit u_execute (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .wb_data    (wb_data),
        .wb_en      (wb_en),
        .next_pc    (next_pc)
    );

    mem_stage u_mem (
        .clk           (clk),
        .reset         (reset),
        .executing     (executing),
        .dec           (dec),
        .alu_result    (alu_result),
        .store_data    (rs2_data),
        .wb_data       (wb_data),
        .wb_en         (wb_en),
        .data_req      (data_req),
        .data_req_data (data_req_data),
        .data_ack      (data_ack),
        .data_rdata    (data_rdata),
        .rf_we         (rf_we),
        .rf_wdata      (rf_wdata),
        .retire        (retire)
    );

    mem_arbiter u_arb (
        .clk           (clk),
        .reset         (reset),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_ack     (fetch_ack),
        .fetch_rdata   (fetch_rdata),
        .data_req      (data_req),
        .data_req_data (data_req_data),
        .data_ack      (data_ack),
        .data_rdata    (data_rdata),
        .mem_req       (mem_req),
        .mem_req_data  (mem_req_data),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/tb_rv_core.sv ====
// rv_core testbench with memory responder, random program and instruction-level model
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module tb_rv_core
    import isa_pkg::*;
    import bus_pkg::*;
;

    localparam int MEM_WORDS = 1024;
    localparam int RETIRES   = 3000;
    localparam int TIMEOUT   = 100;

    logic             clk = 1'b0;
    logic             reset;
    logic             mem_req, mem_ack, retire;
    mem_req_t         mem_req_data;
    logic [`XLEN-1:0] mem_rdata;

    logic [31:0] mem [MEM_WORDS];   // responder memory
    logic [31:0] mmem [MEM_WORDS];  // model copy
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] rng_state = 32'h2983_5aa9;

    logic     s_req, s_ret;  // sampled just before the rising edge
    mem_req_t s_data;

    rv_core DUT (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .retire       (retire)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // one legal instruction for word idx with control flow kept in words 0-255
    function automatic logic [31:0] random_instr(input int idx);
        logic [31:0] r, s, off;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          tgt;
        r   = next_rand();
        s   = next_rand();
        rd  = r[11:7];
        f3  = r[14:12];
        rs1 = r[19:15];
        rs2 = r[24:20];
        imm = s[11:0];
        tgt = s[23:16];
        off = (tgt - idx) * 4;
        if (idx == 255) return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        case (r[31:28])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                if (f3 == 3'b001) imm = {7'b0, s[4:0]};
                if (f3 == 3'b101) imm = {1'b0, s[30], 5'b0, s[4:0]};  // srli or srai
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            4'd4, 4'd5, 4'd6:
                return {1'b0, (f3 == 3'b000 || f3 == 3'b101) ? s[30] : 1'b0, 5'b0,
                        rs2, rs1, f3, rd, 7'b0110011};
            4'd7:  return {s[31:12], rd, 7'b0110111};
            4'd8:  return {s[31:12], rd, 7'b0010111};
            4'd9, 4'd10: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // no branch for funct3 2 and 3
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            4'd11: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            4'd12: return {2'b00, s[23:16], 1'b0, s[31], 5'd0, 3'b000, rd, 7'b1100111};
            4'd13, 4'd14: return {2'b01, s[7:0], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
            default: begin
                imm = {2'b01, s[7:0], 2'b00};  // data words 256-511
                return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            end
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // sample at the rising edge and return on the falling edge
    task automatic tick();
        @(posedge clk);
        s_req  = mem_req;
        s_data = mem_req_data;
        s_ret  = retire;
        @(negedge clk);
    endtask

    task automatic wait_request(output int cycles, input string what);
        cycles = 0;
        do begin
            tick();
            cycles++;
            assert (!s_ret)
                else value_error($sformatf("retire while waiting for the %s", what));
        end while (!s_req && cycles < TIMEOUT);
        if (!s_req) begin
            $display("timeout: no %s within %0d cycles", what, TIMEOUT);
            abort_run();
        end
    endtask

    task automatic check_held(input mem_req_t held);
        assert (s_req) else value_error("request dropped before the acknowledge");
        assert (s_data == held)
            else value_error($sformatf("request changed while held, %h then %h", held, s_data));
    endtask

    // random latency and then a one-cycle acknowledge
    task automatic serve_request(input logic [31:0] rdata, input logic ret_at_ack);
        mem_req_t held;
        int       delay;
        held  = s_data;
        delay = 1 + next_rand() % 6;
        for (int i = 1; i < delay; i++) begin
            tick();
            check_held(held);
            assert (!s_ret) else value_error("retire before the acknowledge");
        end
        mem_ack   = 1'b1;
        mem_rdata = rdata;
        tick();
        check_held(held);
        assert (s_ret == ret_at_ack)
            else value_error($sformatf("retire %0b in ack cycle, expected %0b", s_ret, ret_at_ack));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        if (held.write) mem[held.addr[11:2]] = held.wdata;
    endtask

    task automatic model_exec(input logic [31:0] iw, output logic is_mem, output logic is_st,
                              output logic [31:0] addr, output logic [31:0] sdata);
        logic [31:0] a, b, ii, is, ib, iu, ij, res, npc;
        logic        take, wr;
        a     = (iw[19:15] == 0) ? 32'd0 : m_regs[iw[19:15]];
        b     = (iw[24:20] == 0) ? 32'd0 : m_regs[iw[24:20]];
        ii    = {{20{iw[31]}}, iw[31:20]};
        is    = {{20{iw[31]}}, iw[31:25], iw[11:7]};
        ib    = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
        iu    = {iw[31:12], 12'b0};
        ij    = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        npc   = m_pc + 4;
        wr    = 1'b1;
        res   = '0;
        take  = 1'b0;
        is_mem = 1'b0;
        is_st  = 1'b0;
        addr   = '0;
        sdata  = '0;
        case (iw[6:0])
            OP_LUI:   res = iu;
            OP_AUIPC: res = m_pc + iu;
            OP_JAL: begin
                res = m_pc + 4;
                npc = m_pc + ij;
            end
            OP_JALR: begin
                res = m_pc + 4;
                npc = (a + ii) & ~32'h1;
            end
            OP_BRANCH: begin
                wr = 1'b0;
                case (iw[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) npc = m_pc + ib;
            end
            OP_LOAD: begin
                is_mem = 1'b1;
                addr   = a + ii;
                res    = mmem[addr[11:2]];
            end
            OP_STORE: begin
                wr     = 1'b0;
                is_mem = 1'b1;
                is_st  = 1'b1;
                addr   = a + is;
                sdata  = b;
                mmem[addr[11:2]] = b;
            end
            OP_IMM: res = alu_ref(iw[14:12], iw[30] && iw[14:12] == 3'b101, a, ii);
            OP_REG: res = alu_ref(iw[14:12], iw[30], a, b);
            default: begin
                $display("program holds an unknown opcode %h at pc %h", iw[6:0], m_pc);
                abort_run();
            end
        endcase
        if (wr && iw[11:7] != 0) m_regs[iw[11:7]] = res;
        m_pc = npc;
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = next_rand() ^ i;
        for (int i = 0; i < 256; i++) mem[i] = random_instr(i);
        for (int i = 0; i < MEM_WORDS; i++) mmem[i] = mem[i];
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        m_pc = `RESET_PC;
    endtask

    initial begin
        int          n;
        logic [31:0] iw, rdata, d_addr, d_wdata;
        logic        is_mem, is_st;
        reset     = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        load_program();
        repeat (5) begin
            tick();
            assert (!s_req) else value_error("memory request high during reset");
            assert (!s_ret) else value_error("retire high during reset");
        end
        reset = 1'b0;
        for (int k = 0; k < RETIRES; k++) begin
            wait_request(n, "fetch request");
            assert (n == 1)
                else value_error($sformatf("fetch request after %0d cycles, expected 1", n));
            assert (!s_data.write && s_data.addr == m_pc)
                else value_error($sformatf("fetch at %h write %0b, model pc %h",
                                           s_data.addr, s_data.write, m_pc));
            iw = mem[s_data.addr[11:2]];
            serve_request(iw, 1'b0);
            model_exec(iw, is_mem, is_st, d_addr, d_wdata);
            if (!is_mem) begin
                tick();  // execute cycle
                assert (s_ret) else value_error("no retire one cycle after the fetch ack");
                assert (!s_req) else value_error("request raised by a non-memory instruction");
            end else begin
                wait_request(n, "data request");
                assert (n == 1)
                    else value_error($sformatf("data request after %0d cycles, expected 1", n));
                assert (s_data.addr == d_addr && s_data.write == is_st)
                    else value_error($sformatf("data request addr %h write %0b, model %h %0b",
                                               s_data.addr, s_data.write, d_addr, is_st));
                assert (s_data.wmask == 4'hf)
                    else value_error($sformatf("write mask %h, expected f", s_data.wmask));
                if (is_st) begin
                    assert (s_data.wdata == d_wdata)
                        else value_error($sformatf("store data %h, model %h",
                                                   s_data.wdata, d_wdata));
                end
                rdata = mem[d_addr[11:2]];
                serve_request(rdata, 1'b1);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+include
source/isa_pkg.sv
source/bus_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/mem_stage.sv
source/mem_arbiter.sv
source/reg_file.sv
source/rv_core.sv
verif/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - source/isa_pkg.sv
  - source/bus_pkg.sv
  - source/fetch_unit.sv
  - source/decode_unit.sv
  - source/execute_unit.sv
  - source/mem_stage.sv
  - source/mem_arbiter.sv
  - source/reg_file.sv
  - source/rv_core.sv
  - target: test
    files:
      - verif/tb_rv_core.sv
